// ==== hdl/ro_pkg.sv ====
/*
 * Shared types for the operand-read stage. Holds the operand and register
 * address widths, the producer-lane and read-request structs, and the
 * bypass source encoding. Modules refer to these by scoped name.
 */

`default_nettype none

package ro_pkg;

   // ========================================================================
   // Widths
   // ========================================================================
   localparam int data_w = 64;                     // Integer operand width.
   localparam int reg_aw = 5;                      // 32 architectural registers.

   // ========================================================================
   // Bus structs
   // ========================================================================

   // One result lane of a producer stage. The commit stage also writes the RF.
   typedef struct packed {
      logic               we;                      // Lane carries a register result.
      logic [reg_aw-1:0]  waddr;                   // Destination register.
      logic [data_w-1:0]  wdat;                    // Result value.
   } wb_lane_t;

   // One source-operand read channel.
   typedef struct packed {
      logic               re;                      // Operand is needed this cycle.
      logic [reg_aw-1:0]  raddr;                   // Source register.
   } rd_req_t;

   // ========================================================================
   // Bypass source
   // ========================================================================

   // The stage codes double as indexes into the registered stage buses.
   typedef enum logic [2:0] {
      src_ex_s1 = 3'd0,                            // Execute stage 1, youngest.
      src_ex_s2 = 3'd1,
      src_ex_s3 = 3'd2,
      src_cmt   = 3'd3,                            // Commit stage.
      src_rf    = 3'd4                             // No hit, use the register file.
   } byp_src_e;

endpackage

`default_nettype wire

// ==== hdl/reg_file.sv ====
/*
 * Integer register file with one write port per commit lane and two read
 * ports per issue lane. Read data is registered under the stage enable, so
 * a read issued in one cycle shows its value in the next.
 */

`default_nettype none

module reg_file
#(
   parameter int p_issue_width = 1
)
(
   input  wire                                          clk,
   input  wire                                          arst_n,
   input  wire ro_pkg::wb_lane_t [(1<<p_issue_width)-1:0] wr,
   input  wire ro_pkg::rd_req_t  [(2<<p_issue_width)-1:0] rd,
   input  wire                                          ld,
   output logic [(2<<p_issue_width)-1:0][ro_pkg::data_w-1:0] rdata
);

   localparam int iw    = 1 << p_issue_width;      // Commit lanes.
   localparam int chs   = 2 * iw;                  // Read channels.
   localparam int nregs = 1 << ro_pkg::reg_aw;

   logic [ro_pkg::data_w-1:0] regs [nregs];

   // True when two enabled commit lanes name the same register.
   function automatic logic wr_conflict(input ro_pkg::wb_lane_t [iw-1:0] w);
      logic c;
      c = 1'b0;
      for (int a = 0; a < iw; a++)
      begin
         for (int b = a + 1; b < iw; b++)
         begin
            if (w[a].we && w[b].we && (w[a].waddr == w[b].waddr))
               c = 1'b1;
         end
      end
      return c;
   endfunction

   // ========================================================================
   // Array write
   // ========================================================================
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < nregs; i++)
            regs[i] <= '0;
      end
      else
      begin
         for (int k = 0; k < iw; k++)                 // Later lanes overwrite earlier ones.
         begin
            if (wr[k].we)
               regs[wr[k].waddr] <= wr[k].wdat;
         end
      end
   end

   // ========================================================================
   // Registered read ports
   // ========================================================================
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         rdata <= '0;
      else if (ld)
      begin
         for (int ch = 0; ch < chs; ch++)
            rdata[ch] <= regs[rd[ch].raddr];           // Old value, commit writes land later.
      end
   end

   a_wr_unique: assert property (@(posedge clk) disable iff (!arst_n) !wr_conflict(wr))
      else $error("reg_file: two commit lanes write the same register");

endmodule

`default_nettype wire

// ==== hdl/operand_bypass.sv ====
/*
 * Bypass network for the operand-read stage. Read addresses are compared
 * against every lane of execute stages 1 to 3 and commit in the read cycle.
 * The winning source and lane are registered, and the operand is selected
 * one cycle later. Also flags reads that depend on a lane-0 load.
 */

`default_nettype none

module operand_bypass
#(
   parameter int p_issue_width = 1
)
(
   input  wire                                            clk,
   input  wire                                            arst_n,
   input  wire ro_pkg::wb_lane_t [(1<<p_issue_width)-1:0] ex_s1,
   input  wire ro_pkg::wb_lane_t [(1<<p_issue_width)-1:0] ex_s2,
   input  wire ro_pkg::wb_lane_t [(1<<p_issue_width)-1:0] ex_s3,
   input  wire ro_pkg::wb_lane_t [(1<<p_issue_width)-1:0] cmt,
   input  wire                                            ex_s1_load0,
   input  wire                                            ex_s2_load0,
   input  wire                                            ex_s3_load0,
   input  wire ro_pkg::rd_req_t  [(2<<p_issue_width)-1:0] rd,
   input  wire logic [(2<<p_issue_width)-1:0][ro_pkg::data_w-1:0] rf_din,
   output logic [(2<<p_issue_width)-1:0][ro_pkg::data_w-1:0]      byp_dout,
   output logic [(2<<p_issue_width)-1:0]                          raw_dep_load0,
   output logic                                                   ld
);

   localparam int iw   = 1 << p_issue_width;       // Lanes per stage.
   localparam int chs  = 2 * iw;                   // Read channels.
   localparam int nstg = 4;                        // ex_s1, ex_s2, ex_s3, cmt.
   localparam int lw   = (p_issue_width > 0) ? p_issue_width : 1;

   ro_pkg::wb_lane_t [nstg-1:0][iw-1:0]  stg;      // Index matches byp_src_e.
   logic [chs-1:0]                       re;
   logic [chs-1:0][nstg-1:0][iw-1:0]     hit;
   ro_pkg::byp_src_e                     src_d [chs];
   logic [lw-1:0]                        lane_d [chs];
   ro_pkg::byp_src_e                     src_q [chs];
   logic [lw-1:0]                        lane_q [chs];
   logic [nstg-1:0][iw-1:0][ro_pkg::data_w-1:0] dat_q;

   // Index of the highest set bit, which is the youngest lane.
   function automatic logic [lw-1:0] hi_lane(input logic [iw-1:0] v);
      logic [lw-1:0] idx;
      idx = '0;
      for (int k = 0; k < iw; k++)
      begin
         if (v[k])
            idx = lw'(k);
      end
      return idx;
   endfunction

   assign stg = {cmt, ex_s3, ex_s2, ex_s1};

   // ========================================================================
   // Read cycle: hazard compare
   // ========================================================================
   always_comb
   begin
      for (int ch = 0; ch < chs; ch++)
      begin
         re[ch] = rd[ch].re;
         for (int s = 0; s < nstg; s++)
         begin
            for (int k = 0; k < iw; k++)
               hit[ch][s][k] = rd[ch].re && stg[s][k].we && (stg[s][k].waddr == rd[ch].raddr);
         end
      end
   end

   assign ld = |re;                                // Stage advances when any operand is read.

   always_comb
   begin
      for (int ch = 0; ch < chs; ch++)
      begin
         src_d[ch]  = ro_pkg::src_rf;
         lane_d[ch] = '0;
         for (int s = nstg - 1; s >= 0; s--)          // Walk oldest first so ex_s1 lands last.
         begin
            if (|hit[ch][s])
            begin
               src_d[ch]  = ro_pkg::byp_src_e'(s);
               lane_d[ch] = hi_lane(hit[ch][s]);
            end
         end
      end
   end

   always_comb
   begin
      for (int ch = 0; ch < chs; ch++)
         raw_dep_load0[ch] = (hit[ch][0][0] & ex_s1_load0) |
                             (hit[ch][1][0] & ex_s2_load0) |
                             (hit[ch][2][0] & ex_s3_load0);
   end

   // ========================================================================
   // Stage registers
   // ========================================================================
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int ch = 0; ch < chs; ch++)
         begin
            src_q[ch]  <= ro_pkg::src_rf;
            lane_q[ch] <= '0;
         end
      end
      else if (ld)
      begin
         src_q  <= src_d;
         lane_q <= lane_d;
      end
   end

   always_ff @(posedge clk)
   begin
      if (ld)
      begin
         for (int s = 0; s < nstg; s++)
         begin
            for (int k = 0; k < iw; k++)
               dat_q[s][k] <= stg[s][k].wdat;
         end
      end
   end

   // ========================================================================
   // Select cycle
   // ========================================================================
   always_comb
   begin
      for (int ch = 0; ch < chs; ch++)
      begin
         case (src_q[ch])
            ro_pkg::src_ex_s1: byp_dout[ch] = dat_q[0][lane_q[ch]];
            ro_pkg::src_ex_s2: byp_dout[ch] = dat_q[1][lane_q[ch]];
            ro_pkg::src_ex_s3: byp_dout[ch] = dat_q[2][lane_q[ch]];
            ro_pkg::src_cmt:   byp_dout[ch] = dat_q[3][lane_q[ch]];
            default:           byp_dout[ch] = rf_din[ch];
         endcase
      end
   end

   // A channel that was not read while the stage advanced must fall back to the RF.
   for (genvar ch = 0; ch < chs; ch++)
   begin : g_idle_chk
      a_idle_rf: assert property (@(posedge clk) disable iff (!arst_n)
                                  (ld && !re[ch]) |=> (src_q[ch] == ro_pkg::src_rf))
         else $error("operand_bypass: idle channel %0d kept a bypass source", ch);
   end

endmodule

`default_nettype wire

// ==== hdl/operand_read.sv ====
/*
 * Top level of the operand-read stage. Connects the register file to the
 * bypass network. The network drives the stage enable for both and overrides
 * the registered register-file data with in-flight results.
 */

`default_nettype none

module operand_read
#(
   parameter int p_issue_width = 1                 // Issue lanes as a power of two.
)
(
   input  wire                                            clk,
   input  wire                                            arst_n,
   input  wire ro_pkg::wb_lane_t [(1<<p_issue_width)-1:0] ex_s1,
   input  wire ro_pkg::wb_lane_t [(1<<p_issue_width)-1:0] ex_s2,
   input  wire ro_pkg::wb_lane_t [(1<<p_issue_width)-1:0] ex_s3,
   input  wire ro_pkg::wb_lane_t [(1<<p_issue_width)-1:0] cmt,
   input  wire                                            ex_s1_load0,
   input  wire                                            ex_s2_load0,
   input  wire                                            ex_s3_load0,
   input  wire ro_pkg::rd_req_t  [(2<<p_issue_width)-1:0] rd,
   output logic [(2<<p_issue_width)-1:0][ro_pkg::data_w-1:0] opnd,
   output logic [(2<<p_issue_width)-1:0]                     raw_dep_load0
);

   logic                                                  ld;
   logic [(2<<p_issue_width)-1:0][ro_pkg::data_w-1:0]     rf_rdata;

   reg_file #(.p_issue_width(p_issue_width)) u_reg_file
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr      (cmt),                              // Commit results retire into the array.
      .rd      (rd),
      .ld      (ld),
      .rdata   (rf_rdata)
   );

   operand_bypass #(.p_issue_width(p_issue_width)) u_operand_bypass
   (
      .clk           (clk),
      .arst_n        (arst_n),
      .ex_s1         (ex_s1),
      .ex_s2         (ex_s2),
      .ex_s3         (ex_s3),
      .cmt           (cmt),
      .ex_s1_load0   (ex_s1_load0),
      .ex_s2_load0   (ex_s2_load0),
      .ex_s3_load0   (ex_s3_load0),
      .rd            (rd),
      .rf_din        (rf_rdata),
      .byp_dout      (opnd),
      .raw_dep_load0 (raw_dep_load0),
      .ld            (ld)                          // Shared stage enable.
   );

endmodule

`default_nettype wire

// ==== testbench/tb_operand_read.sv ====
/*
 * Testbench for the operand-read stage. Drives directed and LFSR-random
 * producer and read traffic into the DUT and keeps a shadow register file.
 * Concurrent assertions compare the operands and load-use flags with the
 * values that the shadow model expects.
 */

`default_nettype none

module tb_operand_read;

   localparam int iw         = 2;                     // Lanes at the default width.
   localparam int chs        = 2 * iw;                // Read channels.
   localparam int n_random   = 400;
   localparam int max_cycles = 600;                   // About 430 cycles of test plus margin.
   localparam logic [31:0] lfsr_poly = 32'h8020_0003;

   logic                               clk;
   logic                               arst_n;
   ro_pkg::wb_lane_t [iw-1:0]          ex_s1;
   ro_pkg::wb_lane_t [iw-1:0]          ex_s2;
   ro_pkg::wb_lane_t [iw-1:0]          ex_s3;
   ro_pkg::wb_lane_t [iw-1:0]          cmt;
   logic                               ex_s1_load0;
   logic                               ex_s2_load0;
   logic                               ex_s3_load0;
   ro_pkg::rd_req_t [chs-1:0]          rd;
   logic [chs-1:0][ro_pkg::data_w-1:0] opnd;
   logic [chs-1:0]                     raw_dep_load0;

   logic [31:0]                        lfsr_state = 32'd84339;
   int                                 test_id = 0;
   int                                 fail_cnt = 0;
   int                                 cycle_cnt = 0;
   logic [ro_pkg::data_w-1:0]          shadow [32];   // Expected register file contents.
   logic [chs-1:0][ro_pkg::data_w-1:0] exp_opnd;
   logic [chs-1:0]                     chk_vld;       // Channel was read in the last load.
   int                                 chk_id;
   logic [chs-1:0]                     exp_load;

   operand_read dut0
   (
      .clk           (clk),
      .arst_n        (arst_n),
      .ex_s1         (ex_s1),
      .ex_s2         (ex_s2),
      .ex_s3         (ex_s3),
      .cmt           (cmt),
      .ex_s1_load0   (ex_s1_load0),
      .ex_s2_load0   (ex_s2_load0),
      .ex_s3_load0   (ex_s3_load0),
      .rd            (rd),
      .opnd          (opnd),
      .raw_dep_load0 (raw_dep_load0)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // ========================================================================
   // Helpers
   // ========================================================================

   // Galois LFSR, one step per bit returned.
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[62:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_poly) : (lfsr_state >> 1);
      end
      return v;
   endfunction

   // Only four registers are used, so hits are common.
   function automatic logic [4:0] pool_addr(input logic [1:0] i);
      case (i)
         2'd0:    return 5'd3;
         2'd1:    return 5'd7;
         2'd2:    return 5'd12;
         default: return 5'd29;
      endcase
   endfunction

   function automatic string test_label(input int id);
      case (id)
         1:       return "rf_path";
         2:       return "stage_priority";
         3:       return "lane_priority";
         4:       return "commit_forward";
         5:       return "load_use";
         6:       return "hold";
         7:       return "random";
         default: return "idle";
      endcase
   endfunction

   function automatic ro_pkg::wb_lane_t make_lane(input logic we, input logic [4:0] a,
                                                  input logic [63:0] d);
      ro_pkg::wb_lane_t l;
      l.we    = we;
      l.waddr = a;
      l.wdat  = d;
      return l;
   endfunction

   function automatic ro_pkg::rd_req_t make_read(input logic re, input logic [4:0] a);
      ro_pkg::rd_req_t r;
      r.re    = re;
      r.raddr = a;
      return r;
   endfunction

   // Youngest lane of a stage that writes the register, or -1.
   function automatic int youngest_match(input ro_pkg::wb_lane_t [iw-1:0] bus,
                                         input logic [4:0] a);
      for (int k = iw - 1; k >= 0; k--)
      begin
         if (bus[k].we && (bus[k].waddr == a))
            return k;
      end
      return -1;
   endfunction

   // Operand for a read in this cycle. Earlier stages win, the RF is the fallback.
   function automatic logic [63:0] expected_operand(input ro_pkg::rd_req_t r);
      int k;
      k = youngest_match(ex_s1, r.raddr);
      if (k >= 0)
         return ex_s1[k].wdat;
      k = youngest_match(ex_s2, r.raddr);
      if (k >= 0)
         return ex_s2[k].wdat;
      k = youngest_match(ex_s3, r.raddr);
      if (k >= 0)
         return ex_s3[k].wdat;
      k = youngest_match(cmt, r.raddr);
      if (k >= 0)
         return cmt[k].wdat;
      return shadow[r.raddr];                         // Array before this cycle's commits.
   endfunction

   function automatic logic any_read();
      logic a;
      a = 1'b0;
      for (int ch = 0; ch < chs; ch++)
         a = a | rd[ch].re;
      return a;
   endfunction

   task automatic report_mismatch(input int id, input string what, input int ch,
                                  input logic [63:0] exp_v, input logic [63:0] act_v);
      fail_cnt++;
      $display("error %s: channel %0d %s expected %h actual %h",
               test_label(id), ch, what, exp_v, act_v);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
   endtask

   // ========================================================================
   // Shadow model and checks
   // ========================================================================
   always @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < 32; i++)
            shadow[i] = '0;
         exp_opnd <= '0;
         chk_vld  <= '0;
         chk_id   <= 0;
      end
      else
      begin
         if (any_read())                              // A load cycle, otherwise opnd holds.
         begin
            for (int ch = 0; ch < chs; ch++)
            begin
               exp_opnd[ch] <= expected_operand(rd[ch]);
               chk_vld[ch]  <= rd[ch].re;
            end
            chk_id <= test_id;
         end
         for (int k = 0; k < iw; k++)                 // Commits land after the read.
         begin
            if (cmt[k].we)
               shadow[cmt[k].waddr] = cmt[k].wdat;
         end
      end
   end

   always_comb
   begin
      for (int ch = 0; ch < chs; ch++)
         exp_load[ch] = rd[ch].re &&
                        ((ex_s1_load0 && ex_s1[0].we && (ex_s1[0].waddr == rd[ch].raddr)) ||
                         (ex_s2_load0 && ex_s2[0].we && (ex_s2[0].waddr == rd[ch].raddr)) ||
                         (ex_s3_load0 && ex_s3[0].we && (ex_s3[0].waddr == rd[ch].raddr)));
   end

   for (genvar ch = 0; ch < chs; ch++)
   begin : g_chk
      a_opnd: assert property (@(posedge clk) disable iff (!arst_n)
                               chk_vld[ch] |-> (opnd[ch] == exp_opnd[ch]))
         else report_mismatch($sampled(chk_id), "operand", ch,
                              $sampled(exp_opnd[ch]), $sampled(opnd[ch]));
      a_load: assert property (@(posedge clk) disable iff (!arst_n)
                               raw_dep_load0[ch] == exp_load[ch])
         else report_mismatch($sampled(test_id), "load-use flag", ch,
                              64'($sampled(exp_load[ch])), 64'($sampled(raw_dep_load0[ch])));
   end

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles)
      begin
         $display("timeout: the run did not finish within %0d cycles", max_cycles);
         $display("RESULT: FAIL");
         $fatal(1, "timeout");
      end
   end

   // ========================================================================
   // Stimulus
   // ========================================================================
   task clear_inputs();
      ex_s1       <= '0;
      ex_s2       <= '0;
      ex_s3       <= '0;
      cmt         <= '0;
      ex_s1_load0 <= 1'b0;
      ex_s2_load0 <= 1'b0;
      ex_s3_load0 <= 1'b0;
      rd          <= '0;
   endtask

   task next_cycle(input int id);
      @(posedge clk);
      clear_inputs();
      test_id <= id;
   endtask

   task set_lane(input int s, input int k, input ro_pkg::wb_lane_t l);
      case (s)
         0:       ex_s1[k] <= l;
         1:       ex_s2[k] <= l;
         2:       ex_s3[k] <= l;
         default: cmt[k]   <= l;
      endcase
   endtask

   task random_cycle();
      logic       we;
      logic [1:0] a0;
      logic [1:0] off;
      logic       quiet;
      for (int s = 0; s < 4; s++)
      begin
         a0  = rand_bits(2);
         off = rand_bits(2);
         if (off == 2'd0)
            off = 2'd1;
         for (int k = 0; k < iw; k++)
         begin
            we = rand_bits(1);
            set_lane(s, k, make_lane(we, pool_addr((k == 0) ? a0 : a0 ^ off), rand_bits(64)));
         end
      end
      ex_s1_load0 <= rand_bits(1);
      ex_s2_load0 <= rand_bits(1);
      ex_s3_load0 <= rand_bits(1);
      quiet = (rand_bits(3) == 3'd0);                 // Some cycles stall the stage.
      for (int ch = 0; ch < chs; ch++)
      begin
         we = !quiet && (rand_bits(2) != 2'd0);
         rd[ch] <= make_read(we, pool_addr(rand_bits(2)));
      end
   endtask

   initial
   begin
      arst_n = 1'b0;
      clear_inputs();
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;

      // Fill the four registers, then read them with no producer traffic.
      next_cycle(1);
      cmt[0] <= make_lane(1'b1, 5'd3, 64'h1111_2222_3333_0003);
      cmt[1] <= make_lane(1'b1, 5'd7, 64'h4444_5555_6666_0007);
      next_cycle(1);
      cmt[0] <= make_lane(1'b1, 5'd12, 64'h7777_8888_9999_000c);
      cmt[1] <= make_lane(1'b1, 5'd29, 64'haaaa_bbbb_cccc_001d);
      next_cycle(1);
      for (int ch = 0; ch < chs; ch++)
         rd[ch] <= make_read(1'b1, pool_addr(ch));
      next_cycle(1);
      for (int ch = 0; ch < chs; ch++)
         rd[ch] <= make_read(1'b1, pool_addr(3 - ch));

      for (int first = 0; first < 4; first++)
      begin
         next_cycle(2);
         rd[0] <= make_read(1'b1, 5'd7);
         rd[1] <= make_read(1'b1, 5'd3);
         rd[2] <= make_read(1'b1, 5'd7);
         for (int s = first; s < 4; s++)
            set_lane(s, s % 2, make_lane(1'b1, 5'd7, 64'hb000_0000_0000_0000 + 64'(16 * s + first)));
         set_lane(3, 0, make_lane(1'b1, 5'd3, 64'he000_0000_0000_0000 + 64'(first)));
      end

      for (int s = 0; s < 3; s++)                     // Two commit lanes may not share a register.
      begin
         next_cycle(3);
         rd[1] <= make_read(1'b1, 5'd12);
         rd[3] <= make_read(1'b1, 5'd12);
         set_lane(s, 0, make_lane(1'b1, 5'd12, 64'hc000_0000_0000_0000 + 64'(s)));
         set_lane(s, 1, make_lane(1'b1, 5'd12, 64'hc100_0000_0000_0000 + 64'(s)));
      end

      next_cycle(4);
      cmt[1] <= make_lane(1'b1, 5'd29, 64'hd00d_feed_0000_001d);
      rd[0]  <= make_read(1'b1, 5'd29);
      next_cycle(4);
      rd[3]  <= make_read(1'b1, 5'd29);

      next_cycle(5);
      ex_s1[0]    <= make_lane(1'b1, 5'd3, 64'h5100);
      ex_s1_load0 <= 1'b1;
      rd[0]       <= make_read(1'b1, 5'd3);
      rd[1]       <= make_read(1'b0, 5'd3);       // Enable low, no flag.
      ex_s2[1]    <= make_lane(1'b1, 5'd7, 64'h5201);
      ex_s2_load0 <= 1'b1;
      rd[2]       <= make_read(1'b1, 5'd7);       // Producer in lane 1 only.
      ex_s3[0]    <= make_lane(1'b0, 5'd12, 64'h5300);
      ex_s3_load0 <= 1'b1;
      rd[3]       <= make_read(1'b1, 5'd12);
      next_cycle(5);
      ex_s3[0]    <= make_lane(1'b1, 5'd29, 64'h5310);
      ex_s3_load0 <= 1'b1;
      rd[2]       <= make_read(1'b1, 5'd29);
      ex_s2[0]    <= make_lane(1'b1, 5'd12, 64'h5210);
      rd[3]       <= make_read(1'b1, 5'd12);

      next_cycle(6);
      ex_s2[0] <= make_lane(1'b1, 5'd7, 64'h6200);
      for (int ch = 0; ch < chs; ch++)
         rd[ch] <= make_read(1'b1, pool_addr(ch));
      for (int i = 0; i < 3; i++)
      begin
         next_cycle(6);
         cmt[0] <= make_lane(1'b1, 5'd3, 64'h6300 + 64'(i));
         cmt[1] <= make_lane(1'b1, 5'd7, 64'h6700 + 64'(i));
      end
      next_cycle(6);
      for (int ch = 0; ch < chs; ch++)
         rd[ch] <= make_read(1'b1, pool_addr(ch));

      repeat (n_random)
      begin
         next_cycle(7);
         random_cycle();
      end

      next_cycle(0);
      next_cycle(0);
      @(posedge clk);
      if (fail_cnt == 0)
      begin
         $display("RESULT: PASS");
         $finish;
      end
      else
      begin
         $display("RESULT: FAIL");
         $fatal(1, "checks failed");
      end
   end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/ro_pkg.sv
hdl/reg_file.sv
hdl/operand_bypass.sv
hdl/operand_read.sv
testbench/tb_operand_read.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_operand_read -f build.f \
   && ./obj_dir/Vtb_operand_read > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
